// ==== hw/axis_beat_pkg.sv ====
// ************************************************************
// stream beat package
// widths of the 64-bit payload stream and the byte shift
// between the input stream and the realigned stream
// ************************************************************

`default_nettype none

package axis_beat_pkg;

    // bytes of a beat times eight
    localparam int data_width = 64;

    // one keep bit per byte
    localparam int keep_width = 8;

    // the 20-byte header leaves the payload four bytes into a beat
    localparam int half_keep = 4;

endpackage

`default_nettype wire

// ==== hw/ip_beat_if.sv ====
// ************************************************************
// realigned payload beat
// one strobed beat from the realigner to the frame control,
// no back-pressure
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

interface ip_beat_if;

    logic [axis_beat_pkg::data_width-1:0] data;
    logic [axis_beat_pkg::keep_width-1:0] keep;
    logic valid;
    logic last;
    logic user;

    modport src (output data, keep, valid, last, user);

    modport dst (input data, keep, valid, last, user);

endinterface

`default_nettype wire

// ==== hw/ip_hdr_capture.sv ====
// ************************************************************
// IPv4 header capture
// stores the 20-byte header, checks version, IHL and checksum
// and issues one verdict per complete header
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module ip_hdr_capture (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic [axis_beat_pkg::data_width-1:0] in_data,
    input  logic in_last,
    output logic [3:0] version,
    output logic [3:0] ihl,
    output logic [5:0] dscp,
    output logic [1:0] ecn,
    output logic [15:0] length,
    output logic [15:0] identification,
    output logic [2:0] flags,
    output logic [12:0] fragment_offset,
    output logic [7:0] ttl,
    output logic [7:0] protocol,
    output logic [15:0] header_checksum,
    output logic [31:0] source_ip,
    output logic [31:0] dest_ip,
    output logic hdr_valid,
    output logic hdr_ok,
    output logic hdr_bad,
    output logic error_header_early_termination,
    output logic error_invalid_header,
    output logic error_invalid_checksum
);

    ip_hdr_pkg::hdr_word_t word;
    logic [1:0] beat_cnt;
    logic hdr_beat;
    logic check_pending;
    logic [17:0] word_sum;
    logic [19:0] hdr_sum;
    logic [16:0] fold_1;
    logic [15:0] fold_2;
    logic bad_hdr;
    logic bad_csum;

    function automatic logic [15:0] term_val(input ip_hdr_pkg::csum_term_t t);
        return {t.msb, t.lsb};
    endfunction

    assign word = in_data;
    assign hdr_beat = in_valid && (beat_cnt <= ip_hdr_pkg::hdr_last_beat);

    // beat 2 holds only the destination address in its low half
    always_comb begin
        word_sum = 18'(term_val(word.terms[0])) + 18'(term_val(word.terms[1]));
        if (beat_cnt != ip_hdr_pkg::hdr_last_beat) begin
            word_sum = word_sum + 18'(term_val(word.terms[2]))
                     + 18'(term_val(word.terms[3]));
        end
    end

    // end-around carry, twice covers any carry from the first fold
    assign fold_1 = 17'(hdr_sum[15:0]) + 17'(hdr_sum[19:16]);
    assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

    assign bad_hdr = (version != ip_hdr_pkg::ip_version_v4) || (ihl != ip_hdr_pkg::ip_ihl_min);
    assign bad_csum = fold_2 != ip_hdr_pkg::csum_ok;

    assign hdr_ok = hdr_valid;
    assign hdr_bad = error_invalid_header || error_invalid_checksum;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
            check_pending <= 1'b0;
            hdr_valid <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_invalid_header <= 1'b0;
            error_invalid_checksum <= 1'b0;
        end else begin
            if (in_valid) begin
                if (in_last) begin
                    beat_cnt <= '0;
                end else if (hdr_beat) begin
                    beat_cnt <= beat_cnt + 2'd1;
                end
            end
            check_pending <= hdr_beat && !in_last && (beat_cnt == ip_hdr_pkg::hdr_last_beat);
            error_header_early_termination <= hdr_beat && in_last;
            // header errors take precedence over the checksum
            hdr_valid <= check_pending && !bad_hdr && !bad_csum;
            error_invalid_header <= check_pending && bad_hdr;
            error_invalid_checksum <= check_pending && !bad_hdr && bad_csum;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            hdr_sum <= ((beat_cnt == 2'd0) ? 20'd0 : hdr_sum) + 20'(word_sum);
            case (beat_cnt)
                2'd0: begin
                    version <= word.fields.version;
                    ihl <= word.fields.ihl;
                    dscp <= word.fields.dscp;
                    ecn <= word.fields.ecn;
                    length <= {word.fields.len_hi, word.fields.len_lo};
                    identification <= {word.fields.id_hi, word.fields.id_lo};
                    flags <= word.fields.flags;
                    fragment_offset <= {word.fields.frag_hi, word.fields.frag_lo};
                end
                2'd1: begin
                    ttl <= word.terms[0].msb;
                    protocol <= word.terms[0].lsb;
                    header_checksum <= term_val(word.terms[1]);
                    source_ip <= {term_val(word.terms[2]), term_val(word.terms[3])};
                end
                default: begin
                    dest_ip <= {term_val(word.terms[0]), term_val(word.terms[1])};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/ip_hdr_pkg.sv ====
// ************************************************************
// IPv4 header package
// accepted version and length, checksum target, and one 64-bit
// header word seen both as fields and as checksum terms
// ************************************************************

`default_nettype none

package ip_hdr_pkg;

    localparam logic [3:0] ip_version_v4 = 4'd4;

    // in 32-bit words, options are not supported
    localparam logic [3:0] ip_ihl_min = 4'd5;

    localparam logic [15:0] hdr_bytes = 16'd20;

    // input beat that carries the last four header bytes
    localparam logic [1:0] hdr_last_beat = 2'd2;

    // folded sum over a correct header
    localparam logic [15:0] csum_ok = 16'hFFFF;

    // byte 0 of the word sits in the low bits
    typedef struct packed {
        logic [7:0] frag_lo;
        logic [2:0] flags;
        logic [4:0] frag_hi;
        logic [7:0] id_lo;
        logic [7:0] id_hi;
        logic [7:0] len_lo;
        logic [7:0] len_hi;
        logic [5:0] dscp;
        logic [1:0] ecn;
        logic [3:0] version;
        logic [3:0] ihl;
    } hdr_fields_t;

    // msb is the first byte on the wire, so it takes the lower bits
    typedef struct packed {
        logic [7:0] lsb;
        logic [7:0] msb;
    } csum_term_t;

    typedef union packed {
        hdr_fields_t fields;
        csum_term_t [3:0] terms;
    } hdr_word_t;

endpackage

`default_nettype wire

// ==== hw/ip_payload_align.sv ====
// ************************************************************
// payload realigner
// shifts the input stream down by four bytes so the byte after
// the header lands in byte 0, with a flush beat at frame end
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module ip_payload_align (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic [axis_beat_pkg::data_width-1:0] in_data,
    input  logic [axis_beat_pkg::keep_width-1:0] in_keep,
    input  logic in_last,
    input  logic in_user,
    ip_beat_if.src beat
);

    // upper half of the previous input beat
    logic [axis_beat_pkg::data_width/2-1:0] save_data;
    logic [axis_beat_pkg::half_keep-1:0] save_keep;
    logic save_user;

    // next input beat opens a frame
    logic first;
    logic flush_pending;

    logic upper_used;
    logic emit;
    logic [axis_beat_pkg::data_width/2-1:0] low_data;
    logic [axis_beat_pkg::half_keep-1:0] low_keep;

    assign upper_used = |in_keep[axis_beat_pkg::keep_width-1:axis_beat_pkg::half_keep];

    // the first beat of a frame only fills the save register
    assign emit = flush_pending || (in_valid && !first);

    // flush beat carries the saved half alone
    assign low_data = flush_pending ? '0 : in_data[axis_beat_pkg::data_width/2-1:0];
    assign low_keep = flush_pending ? '0 : in_keep[axis_beat_pkg::half_keep-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            first <= 1'b1;
            flush_pending <= 1'b0;
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= emit;
            flush_pending <= 1'b0;
            if (in_valid) begin
                first <= in_last;
                // a one-beat frame still needs a beat to carry its last
                flush_pending <= in_last && (upper_used || first);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            save_data <= in_data[axis_beat_pkg::data_width-1:axis_beat_pkg::data_width/2];
            save_keep <= in_keep[axis_beat_pkg::keep_width-1:axis_beat_pkg::half_keep];
            save_user <= in_user;
        end
        if (emit) begin
            beat.data <= {low_data, save_data};
            beat.keep <= {low_keep, save_keep};
            if (flush_pending) begin
                beat.last <= 1'b1;
                beat.user <= save_user;
            end else begin
                // frame ends here only if nothing is left for a flush
                beat.last <= in_last && !upper_used;
                beat.user <= in_user && !upper_used;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ip_rx_ctrl.sv ====
// ************************************************************
// IP payload frame control
// gates realigned beats on the header verdict, trims them to the
// IP total length and flags payload early termination
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module ip_rx_ctrl (
    input  logic clk,
    input  logic rst,
    ip_beat_if.dst beat,
    input  logic hdr_ok,
    input  logic hdr_bad,
    input  logic [15:0] length,
    output logic out_valid,
    output logic [axis_beat_pkg::data_width-1:0] out_data,
    output logic [axis_beat_pkg::keep_width-1:0] out_keep,
    output logic out_last,
    output logic out_user,
    output logic busy,
    output logic error_payload_early_termination
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_header,
        st_payload,
        st_drop
    } state_t;

    state_t state;
    state_t state_next;

    // payload bytes still owed to the output
    logic [15:0] rem;
    logic [15:0] rem_next;
    logic [15:0] cur_rem;
    logic active;
    logic [axis_beat_pkg::keep_width-1:0] rem_mask;

    logic fwd;
    logic [axis_beat_pkg::keep_width-1:0] fwd_keep;
    logic fwd_last;
    logic early;

    function automatic logic [axis_beat_pkg::keep_width-1:0] len_mask(input logic [15:0] n);
        logic [axis_beat_pkg::keep_width-1:0] m;
        m = '0;
        for (int i = 0; i < axis_beat_pkg::keep_width; i++) begin
            m[i] = n > 16'(i);
        end
        return m;
    endfunction

    // the verdict can arrive together with the first payload beat
    assign active = (state == st_payload) || (state == st_wait_header && hdr_ok);
    assign cur_rem = (state == st_payload) ? rem : length - ip_hdr_pkg::hdr_bytes;
    assign rem_mask = len_mask(cur_rem);

    always_comb begin
        state_next = state;
        rem_next = cur_rem;
        fwd = 1'b0;
        fwd_keep = beat.keep;
        fwd_last = 1'b0;
        early = 1'b0;

        case (state)
            st_idle: begin
                if (beat.valid && !beat.last) begin
                    state_next = st_wait_header;
                end
            end
            st_wait_header: begin
                if (hdr_ok) begin
                    state_next = st_payload;
                end else if (beat.valid && beat.last) begin
                    // header cut short, or rejected on its final beat
                    state_next = st_idle;
                end else if (hdr_bad) begin
                    state_next = st_drop;
                end
            end
            st_drop: begin
                if (beat.valid && beat.last) begin
                    state_next = st_idle;
                end
            end
            default: ;
        endcase

        if (active && beat.valid) begin
            fwd = 1'b1;
            if (cur_rem <= 16'(axis_beat_pkg::keep_width)) begin
                // length ends in this beat, anything after is padding
                fwd_keep = beat.keep & rem_mask;
                fwd_last = 1'b1;
                early = beat.last && ((beat.keep & rem_mask) != rem_mask);
                state_next = beat.last ? st_idle : st_drop;
            end else begin
                rem_next = cur_rem - 16'(axis_beat_pkg::keep_width);
                fwd_last = beat.last;
                early = beat.last;
                state_next = beat.last ? st_idle : st_payload;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            out_valid <= 1'b0;
            busy <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state <= state_next;
            out_valid <= fwd;
            // stays up through the cycle of the closing output beat
            busy <= (state_next != st_idle) || fwd;
            error_payload_early_termination <= fwd && early;
        end
    end

    always_ff @(posedge clk) begin
        rem <= rem_next;
        if (fwd) begin
            out_data <= beat.data;
            out_keep <= fwd_keep;
            out_last <= fwd_last;
            out_user <= beat.user || early;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ip_rx_top.sv ====
// ************************************************************
// IPv4 frame receiver, 64-bit datapath
// header capture and check in parallel with payload realignment
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module ip_rx_top (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic [axis_beat_pkg::data_width-1:0] in_data,
    input  logic [axis_beat_pkg::keep_width-1:0] in_keep,
    input  logic in_last,
    input  logic in_user,
    output logic hdr_valid,
    output logic [3:0] version,
    output logic [3:0] ihl,
    output logic [5:0] dscp,
    output logic [1:0] ecn,
    output logic [15:0] length,
    output logic [15:0] identification,
    output logic [2:0] flags,
    output logic [12:0] fragment_offset,
    output logic [7:0] ttl,
    output logic [7:0] protocol,
    output logic [15:0] header_checksum,
    output logic [31:0] source_ip,
    output logic [31:0] dest_ip,
    output logic out_valid,
    output logic [axis_beat_pkg::data_width-1:0] out_data,
    output logic [axis_beat_pkg::keep_width-1:0] out_keep,
    output logic out_last,
    output logic out_user,
    output logic busy,
    output logic error_header_early_termination,
    output logic error_payload_early_termination,
    output logic error_invalid_header,
    output logic error_invalid_checksum
);

    ip_beat_if payload_beat ();

    logic hdr_ok;
    logic hdr_bad;

    ip_payload_align u_align (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_keep(in_keep),
        .in_last(in_last),
        .in_user(in_user),
        .beat(payload_beat.src)
    );

    ip_hdr_capture u_hdr (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_last(in_last),
        .version(version),
        .ihl(ihl),
        .dscp(dscp),
        .ecn(ecn),
        .length(length),
        .identification(identification),
        .flags(flags),
        .fragment_offset(fragment_offset),
        .ttl(ttl),
        .protocol(protocol),
        .header_checksum(header_checksum),
        .source_ip(source_ip),
        .dest_ip(dest_ip),
        .hdr_valid(hdr_valid),
        .hdr_ok(hdr_ok),
        .hdr_bad(hdr_bad),
        .error_header_early_termination(error_header_early_termination),
        .error_invalid_header(error_invalid_header),
        .error_invalid_checksum(error_invalid_checksum)
    );

    ip_rx_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .beat(payload_beat.dst),
        .hdr_ok(hdr_ok),
        .hdr_bad(hdr_bad),
        .length(length),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_keep(out_keep),
        .out_last(out_last),
        .out_user(out_user),
        .busy(busy),
        .error_payload_early_termination(error_payload_early_termination)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the IPv4 receiver testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_ip_rx -o sim_ip_rx

# keep running past assertion errors so the testbench reports them
./obj_dir/sim_ip_rx +verilator+error+limit+100 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

// ==== testbench/ip_rx_checker.sv ====
// ************************************************************
// protocol checks for the IPv4 frame receiver
// error strobes, header verdict, busy and keep shape
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module ip_rx_checker (
    input logic clk,
    input logic rst,
    input logic hdr_valid,
    input logic out_valid,
    input logic [axis_beat_pkg::keep_width-1:0] out_keep,
    input logic busy,
    input logic error_header_early_termination,
    input logic error_payload_early_termination,
    input logic error_invalid_header,
    input logic error_invalid_checksum
);

    localparam logic [axis_beat_pkg::keep_width-1:0] keep_one =
        {{(axis_beat_pkg::keep_width-1){1'b0}}, 1'b1};

    int fail_count = 0;
    logic [3:0] errs;

    assign errs = {error_header_early_termination, error_payload_early_termination,
                   error_invalid_header, error_invalid_checksum};

    a_one_error: assert property (@(posedge clk) disable iff (rst) $onehot0(errs))
        else begin
            fail_count++;
            $error("more than one error strobe in a cycle");
        end

    // a header is either accepted or rejected, never both
    a_verdict: assert property (@(posedge clk) disable iff (rst)
        !(hdr_valid && (error_invalid_header || error_invalid_checksum)))
        else begin
            fail_count++;
            $error("hdr_valid together with a header error");
        end

    a_busy: assert property (@(posedge clk) disable iff (rst) out_valid |-> busy)
        else begin
            fail_count++;
            $error("out_valid while busy is low");
        end

    // contiguous from bit 0
    a_keep: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> ((out_keep & (out_keep + keep_one)) == '0))
        else begin
            fail_count++;
            $error("out_keep not contiguous");
        end

endmodule

bind ip_rx_top ip_rx_checker chk (.*);

`default_nettype wire

// ==== testbench/tb_ip_rx.sv ====
// ************************************************************
// testbench for the IPv4 frame receiver
// drives a table of frames with random payload and idle gaps,
// checks header fields, realigned payload and error strobes
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_ip_rx;

    // err bits: header early, payload early, bad header, bad checksum
    typedef struct packed {
        logic [15:0] plen;
        logic [15:0] pad;
        logic [7:0] vihl;
        logic corrupt;
        logic [15:0] trunc;
        logic [3:0] err;
    } row_t;

    typedef struct packed {
        logic [axis_beat_pkg::data_width-1:0] data;
        logic [axis_beat_pkg::keep_width-1:0] keep;
        logic last;
        logic user;
    } beat_t;

    typedef logic [159:0] hdr_vec_t;

    localparam int n_rows = 10;
    localparam int gap_max = 6;

    // vihl 0 keeps version 4 and IHL 5, trunc 0 sends the whole frame
    row_t rows [n_rows] = '{
        '{16'd13, 16'd0, 8'h00, 1'b0, 16'd0, 4'b0000},
        '{16'd27, 16'd19, 8'h00, 1'b0, 16'd0, 4'b0000},
        '{16'd30, 16'd0, 8'h00, 1'b1, 16'd0, 4'b0001},
        '{16'd24, 16'd0, 8'h65, 1'b0, 16'd0, 4'b0010},
        '{16'd24, 16'd6, 8'h46, 1'b0, 16'd0, 4'b0010},
        '{16'd40, 16'd0, 8'h00, 1'b0, 16'd12, 4'b1000},
        '{16'd40, 16'd0, 8'h00, 1'b0, 16'd45, 4'b0100},
        '{16'd64, 16'd0, 8'h00, 1'b0, 16'd0, 4'b0000},
        '{16'd9, 16'd37, 8'h00, 1'b0, 16'd0, 4'b0000},
        '{16'd33, 16'd0, 8'h00, 1'b0, 16'd20, 4'b1000}
    };

    logic clk;
    logic rst;
    logic in_valid;
    logic [axis_beat_pkg::data_width-1:0] in_data;
    logic [axis_beat_pkg::keep_width-1:0] in_keep;
    logic in_last;
    logic in_user;
    logic hdr_valid;
    logic [3:0] version;
    logic [3:0] ihl;
    logic [5:0] dscp;
    logic [1:0] ecn;
    logic [15:0] length;
    logic [15:0] identification;
    logic [2:0] flags;
    logic [12:0] fragment_offset;
    logic [7:0] ttl;
    logic [7:0] protocol;
    logic [15:0] header_checksum;
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
    logic out_valid;
    logic [axis_beat_pkg::data_width-1:0] out_data;
    logic [axis_beat_pkg::keep_width-1:0] out_keep;
    logic out_last;
    logic out_user;
    logic busy;
    logic error_header_early_termination;
    logic error_payload_early_termination;
    logic error_invalid_header;
    logic error_invalid_checksum;
    logic [3:0] errs;

    logic [7:0] frame [$];
    hdr_vec_t exp_hdr [$];
    int exp_hdr_idx [$];
    beat_t exp_beats [$];
    int exp_beat_idx [$];
    int done_count = 0;
    int errors = 0;
    int checks = 0;
    int test_start_err = 0;

    assign errs = {error_header_early_termination, error_payload_early_termination,
                   error_invalid_header, error_invalid_checksum};

    ip_rx_top uut (.*);

    task automatic check_hdr(input int idx, input hdr_vec_t exp);
        hdr_vec_t got;
        got = {version, ihl, dscp, ecn, length, identification, flags, fragment_offset,
               ttl, protocol, header_checksum, source_ip, dest_ip};
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: test %0d header %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_beat(input int idx,
                              input logic [axis_beat_pkg::data_width-1:0] data,
                              input logic [axis_beat_pkg::keep_width-1:0] keep,
                              input logic last, input logic user, input beat_t exp);
        logic [axis_beat_pkg::data_width-1:0] mask;
        for (int i = 0; i < axis_beat_pkg::keep_width; i++) begin
            mask[8*i +: 8] = {8{exp.keep[i]}};
        end
        checks++;
        if ((data & mask) !== exp.data || keep !== exp.keep || last !== exp.last
                || user !== exp.user) begin
            errors++;
            $display("ERROR at %0t: test %0d beat %h/%h/%b/%b, expected %h/%h/%b/%b", $time,
                     idx, data & mask, keep, last, user, exp.data, exp.keep, exp.last, exp.user);
        end
    endtask

    task automatic check_err(input int idx, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: test %0d error strobes %b, expected %b", $time, idx, got, exp);
        end
    endtask

    // frame bytes with checksum, then the expected outputs
    task automatic build_frame(input int r, output int sent);
        int total;
        int hdr_len;
        int n;
        logic [15:0] len16;
        logic [15:0] csum;
        logic [16:0] acc;
        hdr_vec_t hv;
        beat_t b;
        hdr_len = int'(ip_hdr_pkg::hdr_bytes);
        total = hdr_len + int'(rows[r].plen) + int'(rows[r].pad);
        frame.delete();
        for (int i = 0; i < total; i++) begin
            frame.push_back(8'($urandom));
        end
        frame[0] = (rows[r].vihl != 8'h00) ? rows[r].vihl
                 : {ip_hdr_pkg::ip_version_v4, ip_hdr_pkg::ip_ihl_min};
        len16 = ip_hdr_pkg::hdr_bytes + rows[r].plen;
        frame[2] = len16[15:8];
        frame[3] = len16[7:0];
        frame[10] = 8'h00;
        frame[11] = 8'h00;
        csum = 16'h0000;
        for (int i = 0; i < hdr_len / 2; i++) begin
            acc = {1'b0, csum} + {1'b0, frame[2*i], frame[2*i+1]};
            csum = acc[15:0] + {15'd0, acc[16]};
        end
        // ones' complement of the folded sum
        csum = ip_hdr_pkg::csum_ok ^ csum;
        if (rows[r].corrupt) begin
            csum = csum ^ 16'h0100;
        end
        frame[10] = csum[15:8];
        frame[11] = csum[7:0];
        sent = (rows[r].trunc != 16'd0) ? int'(rows[r].trunc) : total;

        n = 0;
        if (rows[r].err == 4'b0000 || rows[r].err == 4'b0100) begin
            hv = '0;
            for (int i = 0; i < hdr_len; i++) begin
                hv = {hv[151:0], frame[i]};
            end
            exp_hdr.push_back(hv);
            exp_hdr_idx.push_back(r);
            n = sent - hdr_len;
            if (n > int'(rows[r].plen)) begin
                n = int'(rows[r].plen);
            end
        end
        for (int k = 0; k < n; k += axis_beat_pkg::keep_width) begin
            b = '0;
            for (int i = 0; i < axis_beat_pkg::keep_width; i++) begin
                if (k + i < n) begin
                    b.data[8*i +: 8] = frame[hdr_len + k + i];
                    b.keep[i] = 1'b1;
                end
            end
            b.last = (k + axis_beat_pkg::keep_width >= n);
            b.user = b.last && (n < int'(rows[r].plen));
            exp_beats.push_back(b);
            exp_beat_idx.push_back(r);
        end
    endtask

    task automatic send_frame(input int sent);
        int nb;
        nb = (sent + axis_beat_pkg::keep_width - 1) / axis_beat_pkg::keep_width;
        for (int b = 0; b < nb; b++) begin
            in_data = '0;
            in_keep = '0;
            for (int i = 0; i < axis_beat_pkg::keep_width; i++) begin
                if (b * axis_beat_pkg::keep_width + i < sent) begin
                    in_data[8*i +: 8] = frame[b * axis_beat_pkg::keep_width + i];
                    in_keep[i] = 1'b1;
                end
            end
            in_valid = 1'b1;
            in_last = (b == nb - 1);
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        in_data = '0;
        in_keep = '0;
    endtask

    // the flush beat has left the DUT by the fourth idle cycle
    task automatic idle_gap(input int idx, input int gap);
        for (int k = 0; k < gap; k++) begin
            if (k == 3 && busy !== 1'b0) begin
                errors++;
                $display("ERROR at %0t: busy high in the gap after test %0d", $time, idx);
            end
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (hdr_valid) begin
                if (exp_hdr_idx.size() > 0 && exp_hdr_idx[0] == done_count) begin
                    check_hdr(done_count, exp_hdr[0]);
                    exp_hdr.delete(0);
                    exp_hdr_idx.delete(0);
                end else begin
                    errors++;
                    $display("test %0d: a header came out that was not expected", done_count);
                end
            end
            if (out_valid) begin
                if (exp_beat_idx.size() > 0 && exp_beat_idx[0] == done_count) begin
                    check_beat(done_count, out_data, out_keep, out_last, out_user, exp_beats[0]);
                    exp_beats.delete(0);
                    exp_beat_idx.delete(0);
                end else begin
                    errors++;
                    $display("test %0d: a payload beat came out that was not expected",
                             done_count);
                end
            end
            if ((out_valid && out_last) || errs != 4'b0000) begin
                if (done_count >= n_rows) begin
                    errors++;
                    $display("output seen after the last test had ended");
                end else begin
                    while (exp_hdr_idx.size() > 0 && exp_hdr_idx[0] == done_count) begin
                        errors++;
                        $display("test %0d: the header never came out", done_count);
                        exp_hdr.delete(0);
                        exp_hdr_idx.delete(0);
                    end
                    while (exp_beat_idx.size() > 0 && exp_beat_idx[0] == done_count) begin
                        errors++;
                        $display("test %0d: a payload beat never came out", done_count);
                        exp_beats.delete(0);
                        exp_beat_idx.delete(0);
                    end
                    check_err(done_count, errs, rows[done_count].err);
                    $display("test %0d finished with %0d errors", done_count,
                             errors - test_start_err);
                    test_start_err = errors;
                    done_count++;
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 200 + 3;
        #1;
        for (int r = 0; r < n_rows; r++) begin
            cycles += (int'(rows[r].plen) + int'(rows[r].pad) + int'(ip_hdr_pkg::hdr_bytes)
                       + axis_beat_pkg::keep_width - 1) / axis_beat_pkg::keep_width;
            cycles += gap_max + int'(ip_hdr_pkg::hdr_last_beat) + axis_beat_pkg::half_keep;
        end
        #(cycles * 40);
        $display("timeout: the outputs of all tests did not arrive within %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int sent;
        int total_err;
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_user = 1'b0;
        void'($urandom(45557));
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            build_frame(r, sent);
            send_frame(sent);
            idle_gap(r, 1 + int'($urandom_range(gap_max - 1)));
        end
        wait (done_count == n_rows);
        repeat (4) @(posedge clk);
        #2;
        if (busy !== 1'b0) begin
            errors++;
            $display("ERROR at %0t: busy still high after the last frame", $time);
        end
        if (exp_hdr.size() != 0 || exp_beats.size() != 0) begin
            errors++;
            $display("expected outputs were left over after the last test");
        end
        total_err = errors + uut.chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", done_count,
                 checks, errors, uut.chk.fail_count);
        if (total_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/axis_beat_pkg.sv
hw/ip_hdr_pkg.sv
hw/ip_beat_if.sv
hw/ip_payload_align.sv
hw/ip_hdr_capture.sv
hw/ip_rx_ctrl.sv
hw/ip_rx_top.sv
testbench/ip_rx_checker.sv
testbench/tb_ip_rx.sv
